/* Makefile */
# Verilator build and run of the core wrapper testbench
# pass or fail comes from a search of the run log for the pass message

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables (override on the command line):"
	@echo "  VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(SIM_BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+dv
verilog/core_pkg.sv
verilog/core_settings.sv
verilog/video_line_tracker.sv
verilog/video_output_shaper.sv
verilog/core_top.sv
dv/tb_core_top.sv

/* dv/tb_cases.svh */
//////////////////////////////
// case table of the core wrapper testbench, one row per case;
// included inside the testbench module
//////////////////////////////

`ifndef tb_cases_svh
`define tb_cases_svh

localparam int num_cases = 6;
localparam int num_cols  = 11;

// column positions in a row
localparam int col_sgx       = 0;
localparam int col_turbo     = 1;
localparam int col_sprites   = 2;
localparam int col_reset     = 3;
localparam int col_dot       = 4;
localparam int col_overscan  = 5;
localparam int col_active_px = 6;
localparam int col_border_px = 7;
localparam int col_width     = 8;
localparam int col_lines     = 9;
localparam int col_slot      = 10;

// columns: sgx, turbo tap, extra sprites, reset write, dot mode, overscan,
//          active pixels, border pixels, expected width, expected lines, expected slot
int case_table [num_cases][num_cols] = '{
  '{1, 0, 1, 1, 1, 0, 320,  0, 352, 240, 1},
  '{0, 1, 0, 0, 2, 1, 500,  0, 512, 224, 0},
  '{1, 1, 1, 0, 0, 0, 256,  0, 512, 240, 0},
  '{0, 0, 1, 0, 1, 1, 345,  8, 352, 224, 2},
  '{1, 0, 0, 0, 2, 0, 470, 10, 512, 240, 2},
  '{0, 1, 1, 1, 0, 1, 300,  0, 512, 224, 1}
};

`endif

/* dv/tb_core_top.sv */
//////////////////////////////
// testbench of the core wrapper top; applies the case table,
// draws one raw frame per case and checks settings, reset and video
//////////////////////////////

`timescale 1ns/1ps

module tb_core_top
  import core_pkg::*;
();

  `include "tb_cases.svh"

  localparam int hold_cycles  = 40;
  localparam int line_len     = 560;
  localparam int h_start      = 20;
  localparam int hs_len       = 4;
  localparam int vs_lines     = 2;
  localparam int top_lines    = 4;
  localparam int active_lines = 240;
  localparam int frame_total  = 246;
  localparam logic [31:0] addr_unused = 32'h0000_0008;

  logic                    clk_74a;
  logic                    pll_core_locked;
  logic                    bridge_wr;
  logic [bridge_width-1:0] bridge_addr;
  logic [bridge_width-1:0] bridge_wr_data;
  logic                    h_blank;
  logic                    v_blank;
  logic                    hsync_core;
  logic                    vsync_core;
  logic                    border;
  logic [rgb_width-1:0]    rgb_core;
  dot_mode_t               dotclock_divider;
  logic                    sgx;
  logic                    turbo_tap_enable;
  logic                    extra_sprites_enable;
  logic                    core_reset;
  logic [rgb_width-1:0]    video_rgb;
  logic                    video_de;
  logic                    video_hs;
  logic                    video_vs;

  int                      error_count = 0;
  int                      total_lines = 0;
  logic                    timed_out = 1'b0;
  logic                    pixel_expected;
  logic                    vs_start;
  logic                    hs_start;
  int                      want_width = 0;
  logic [rgb_width-1:0]    want_word = '0;

  // monitor history
  logic                    de_last;
  logic [hs_hold-1:0]      hs_pipe;
  int                      de_run;

  core_top #(
    .reset_hold_cycles(hold_cycles)
  ) u_dut (
    .clk_74a             (clk_74a),
    .pll_core_locked     (pll_core_locked),
    .bridge_wr           (bridge_wr),
    .bridge_addr         (bridge_addr),
    .bridge_wr_data      (bridge_wr_data),
    .h_blank             (h_blank),
    .v_blank             (v_blank),
    .hsync_core          (hsync_core),
    .vsync_core          (vsync_core),
    .border              (border),
    .rgb_core            (rgb_core),
    .dotclock_divider    (dotclock_divider),
    .sgx                 (sgx),
    .turbo_tap_enable    (turbo_tap_enable),
    .extra_sprites_enable(extra_sprites_enable),
    .core_reset          (core_reset),
    .video_rgb           (video_rgb),
    .video_de            (video_de),
    .video_hs            (video_hs),
    .video_vs            (video_vs)
  );

  initial begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  task automatic check_equal(input string what, input longint got, input longint want);
    assert (got == want) else begin
      $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
      error_count++;
    end
  endtask

  task automatic idle_video();
    h_blank        = 1'b1;
    v_blank        = 1'b1;
    hsync_core     = 1'b0;
    vsync_core     = 1'b0;
    border         = 1'b0;
    rgb_core       = '0;
    pixel_expected = 1'b0;
    vs_start       = 1'b0;
    hs_start       = 1'b0;
  endtask

  // one-cycle strobe; returns on the falling edge after the capture edge
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_74a);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr      = 1'b0;
  endtask

  task automatic apply_settings(input int row);
    int v_sgx;
    int v_turbo;
    int v_sprites;
    v_sgx     = case_table[row][col_sgx];
    v_turbo   = case_table[row][col_turbo];
    v_sprites = case_table[row][col_sprites];
    // upper data bits are noise and only bit 0 counts
    bridge_write(addr_sgx, ($urandom() & 32'hffff_fffe) | 32'(v_sgx));
    check_equal("sgx", sgx, v_sgx);
    bridge_write(addr_turbo_tap, ($urandom() & 32'hffff_fffe) | 32'(v_turbo));
    check_equal("turbo_tap_enable", turbo_tap_enable, v_turbo);
    bridge_write(addr_extra_sprites, ($urandom() & 32'hffff_fffe) | 32'(v_sprites));
    check_equal("extra_sprites_enable", extra_sprites_enable, v_sprites);
    bridge_write(addr_overscan, 32'(case_table[row][col_overscan]));
    bridge_write(addr_unused, 32'hffff_ffff);
    check_equal("sgx after unused write", sgx, v_sgx);
    check_equal("turbo_tap_enable after unused write", turbo_tap_enable, v_turbo);
    check_equal("extra_sprites_enable after unused write", extra_sprites_enable, v_sprites);
  endtask

  task automatic check_reset_hold();
    int held;
    check_equal("core_reset before write", core_reset, 0);
    bridge_write(addr_reset, $urandom());
    held = 0;
    while (core_reset && (held < hold_cycles * 4)) begin
      held++;
      @(negedge clk_74a);
    end
    if (core_reset) begin
      $display("timeout: core_reset still high after %0d cycles", held);
      timed_out = 1'b1;
    end else begin
      check_equal("core_reset hold cycles", held, hold_cycles);
    end
  endtask

  // raw frame with vsync on the first lines, then blank lines, then active lines
  task automatic draw_frame(input int active_px, input int border_px);
    int   line;
    int   px;
    int   mask;
    logic line_active;
    mask = (border_px > 0) ? border_px + border_hold : 0;
    for (line = 0; line < frame_total; line++) begin
      line_active = (line >= top_lines) && (line < top_lines + active_lines);
      for (px = 0; px < line_len; px++) begin
        @(negedge clk_74a);
        hsync_core     = (px < hs_len);
        vsync_core     = (line < vs_lines);
        hs_start       = (px == 0);
        vs_start       = (line == 0) && (px == 0);
        v_blank        = !line_active;
        h_blank        = !(line_active && (px >= h_start) && (px < h_start + active_px));
        border         = line_active && (px >= h_start) && (px < h_start + border_px);
        pixel_expected = line_active && (px >= h_start + mask) && (px < h_start + active_px);
        rgb_core       = rgb_width'($urandom());
      end
    end
    @(negedge clk_74a);
    idle_video();
  endtask

  task automatic wait_for_lines(input int first, input int count);
    int waited;
    waited = 0;
    while (((total_lines - first) < count) && (waited < line_len * 2)) begin
      waited++;
      @(negedge clk_74a);
    end
    if ((total_lines - first) < count) begin
      $display("timeout: only %0d of %0d stretched lines seen", total_lines - first, count);
      timed_out = 1'b1;
    end else begin
      check_equal("stretched lines per frame", total_lines - first, count);
    end
  endtask

  //////////////////////////////
  // video monitor
  //////////////////////////////

  always @(posedge clk_74a) begin
    if (!pll_core_locked) begin
      de_last = 1'b0;
      hs_pipe = '0;
      de_run  = 0;
    end else begin
      check_equal("video_vs", video_vs, vs_start);
      // hsync rise from hs_hold cycles back
      check_equal("video_hs", video_hs, hs_pipe[hs_hold-1]);
      if (pixel_expected) begin
        check_equal("video_rgb on active pixel", video_rgb, rgb_core);
      end else if (de_last && !video_de) begin
        check_equal("end-of-line mode word", video_rgb, want_word);
      end else begin
        check_equal("video_rgb outside active pixels", video_rgb, 0);
      end
      if (video_de) begin
        de_run++;
      end else if (de_last) begin
        check_equal("video_de pixels per line", de_run, want_width);
        total_lines++;
        de_run = 0;
      end
      hs_pipe = {hs_pipe[hs_hold-2:0], hs_start};
      de_last = video_de;
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int row;
    int errs_before;
    int lines_before;
    int ran;
    int failing;
    ran     = 0;
    failing = 0;
    void'($urandom(39));
    pll_core_locked  = 1'b0;
    bridge_wr        = 1'b0;
    bridge_addr      = '0;
    bridge_wr_data   = '0;
    dotclock_divider = dot_256;
    idle_video();
    repeat (10) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    @(negedge clk_74a);

    check_equal("sgx after reset", sgx, 0);
    check_equal("turbo_tap_enable after reset", turbo_tap_enable, 0);
    check_equal("extra_sprites_enable after reset", extra_sprites_enable, 0);
    check_equal("core_reset after reset", core_reset, 0);
    check_equal("video_de after reset", video_de, 0);

    for (row = 0; row < num_cases; row++) begin
      errs_before = error_count;
      apply_settings(row);
      if (case_table[row][col_reset] != 0) begin
        check_reset_hold();
      end
      if (timed_out) begin
        break;
      end
      dotclock_divider = dot_mode_t'(case_table[row][col_dot]);
      want_width       = case_table[row][col_width];
      // slot in bits 15:14, overscan in bit 13
      want_word        = (rgb_width'(case_table[row][col_slot]) << 14) |
                         (rgb_width'(case_table[row][col_overscan]) << 13);
      lines_before     = total_lines;
      draw_frame(case_table[row][col_active_px], case_table[row][col_border_px]);
      wait_for_lines(lines_before, case_table[row][col_lines]);
      ran++;
      if ((error_count == errs_before) && !timed_out) begin
        $display("case %0d: ok", row);
      end else begin
        $display("case %0d: %0d errors", row, error_count - errs_before);
        failing++;
      end
    end

    $display("cases run: %0d, cases failing: %0d, errors: %0d", ran, failing, error_count);
    if (timed_out || (error_count != 0)) begin
      $display("Checks failed");
    end else begin
      $display("All checks passed");
    end
    $finish;
  end

endmodule

/* verilog/core_pkg.sv */
//////////////////////////////
// shared widths, bridge setting addresses, video limits and
// enums of the core wrapper; imported by each module that needs them
//////////////////////////////

package core_pkg;

  //////////////////////////////
  // host bridge
  //////////////////////////////

  localparam int bridge_width = 32;

  // one word per setting
  localparam logic [bridge_width-1:0] addr_sgx           = 32'h0000_0004;
  localparam logic [bridge_width-1:0] addr_reset         = 32'h0000_0050;
  localparam logic [bridge_width-1:0] addr_turbo_tap     = 32'h0000_0100;
  localparam logic [bridge_width-1:0] addr_overscan      = 32'h0000_0200;
  localparam logic [bridge_width-1:0] addr_extra_sprites = 32'h0000_0204;

  // default length of the held core reset, in clk_74a cycles
  localparam int unsigned reset_hold_cycles = 32'h0010_0000;

  //////////////////////////////
  // video
  //////////////////////////////

  localparam int rgb_width         = 24;
  localparam int pixel_count_width = 10;
  localparam int line_count_width  = 9;

  // expected pixels per line
  localparam logic [pixel_count_width-1:0] line_width_narrow = 10'd352;
  localparam logic [pixel_count_width-1:0] line_width_wide   = 10'd512;

  // expected lines per frame
  localparam logic [line_count_width-1:0] lines_full     = 9'd240;
  localparam logic [line_count_width-1:0] lines_overscan = 9'd224;

  // border input drops a few pixels early, so masking is held on
  localparam int border_hold        = 4;
  localparam int border_count_width = $clog2(border_hold + 1);
  localparam logic [pixel_count_width-1:0] border_pixels = 10'd24;

  // hsync is pushed back so it never lands on the vsync pulse
  localparam int hs_hold        = 6;
  localparam int hs_count_width = $clog2(hs_hold + 1);

  // widest-line limits for mode detection
  localparam logic [pixel_count_width-1:0] slot_thresh_512 = 10'd480;
  localparam logic [pixel_count_width-1:0] slot_thresh_352 = 10'd330;
  localparam logic [pixel_count_width-1:0] slot_thresh_320 = 10'd280;

  // dot clock divider from the console
  typedef enum logic [1:0] {
    dot_256 = 2'd0,
    dot_352 = 2'd1,
    dot_512 = 2'd2
  } dot_mode_t;

  // mode code reported to the scaler
  typedef enum logic [1:0] {
    slot_256 = 2'd0,
    slot_320 = 2'd1,
    slot_352 = 2'd2
  } video_slot_t;

endpackage

/* verilog/core_settings.sv */
//////////////////////////////
// turns host bridge writes into setting levels for the console
// and holds the core in reset for a fixed count after a reset write
//////////////////////////////

`timescale 1ns/1ps

module core_settings
  import core_pkg::*;
#(
  parameter int unsigned reset_hold_cycles = core_pkg::reset_hold_cycles
) (
  input  logic                    clk_74a,
  input  logic                    pll_core_locked,

  input  logic                    bridge_wr,
  input  logic [bridge_width-1:0] bridge_addr,
  input  logic [bridge_width-1:0] bridge_wr_data,

  output logic                    sgx,
  output logic                    turbo_tap_enable,
  output logic                    overscan_enable,
  output logic                    extra_sprites_enable,
  output logic                    core_reset
);

  localparam int hold_width = $clog2(reset_hold_cycles + 1);

  logic [hold_width-1:0] hold_count;
  logic                  reset_write;

  assign reset_write = bridge_wr && (bridge_addr == addr_reset);

  //////////////////////////////
  // setting levels
  //////////////////////////////

  // each setting takes bit 0 of its word
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      sgx                  <= 1'b0;
      turbo_tap_enable     <= 1'b0;
      overscan_enable      <= 1'b0;
      extra_sprites_enable <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        addr_sgx: begin
          sgx <= bridge_wr_data[0];
        end
        addr_turbo_tap: begin
          turbo_tap_enable <= bridge_wr_data[0];
        end
        addr_overscan: begin
          overscan_enable <= bridge_wr_data[0];
        end
        addr_extra_sprites: begin
          extra_sprites_enable <= bridge_wr_data[0];
        end
        default: begin
          // unused addresses fall through
        end
      endcase
    end
  end

  //////////////////////////////
  // held core reset
  //////////////////////////////

  // a new reset write restarts the count from the top
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_count <= '0;
    end else if (reset_write) begin
      hold_count <= hold_width'(reset_hold_cycles);
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 1'b1;
    end
  end

  // high for exactly reset_hold_cycles cycles after the write
  assign core_reset = (hold_count != '0);

endmodule

/* verilog/core_top.sv */
//////////////////////////////
// core wrapper top: bridge settings plus video shaping between
// the emulated console and the scaler, all on clk_74a
//////////////////////////////

`timescale 1ns/1ps

module core_top
  import core_pkg::*;
#(
  parameter int unsigned reset_hold_cycles = core_pkg::reset_hold_cycles
) (
  input  logic                    clk_74a,
  input  logic                    pll_core_locked,

  // host bridge
  input  logic                    bridge_wr,
  input  logic [bridge_width-1:0] bridge_addr,
  input  logic [bridge_width-1:0] bridge_wr_data,

  // raw video from the console
  input  logic                    h_blank,
  input  logic                    v_blank,
  input  logic                    hsync_core,
  input  logic                    vsync_core,
  input  logic                    border,
  input  logic [rgb_width-1:0]    rgb_core,
  input  dot_mode_t               dotclock_divider,

  // settings to the console
  output logic                    sgx,
  output logic                    turbo_tap_enable,
  output logic                    extra_sprites_enable,
  output logic                    core_reset,

  // video to the scaler
  output logic [rgb_width-1:0]    video_rgb,
  output logic                    video_de,
  output logic                    video_hs,
  output logic                    video_vs
);

  logic                         overscan_enable;
  logic                         hs_rise;
  logic                         vs_rise;
  logic                         raw_de;
  logic                         border_active;
  logic [pixel_count_width-1:0] pixel_count;
  logic [line_count_width-1:0]  line_count;
  logic                         line_started;
  logic                         frame_started;
  video_slot_t                  video_slot;
  logic                         de_stretched;
  logic                         de_stretched_prev;

  core_settings #(
    .reset_hold_cycles(reset_hold_cycles)
  ) u_settings (
    .clk_74a             (clk_74a),
    .pll_core_locked     (pll_core_locked),
    .bridge_wr           (bridge_wr),
    .bridge_addr         (bridge_addr),
    .bridge_wr_data      (bridge_wr_data),
    .sgx                 (sgx),
    .turbo_tap_enable    (turbo_tap_enable),
    .overscan_enable     (overscan_enable),
    .extra_sprites_enable(extra_sprites_enable),
    .core_reset          (core_reset)
  );

  video_line_tracker u_tracker (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .h_blank          (h_blank),
    .v_blank          (v_blank),
    .hsync_core       (hsync_core),
    .vsync_core       (vsync_core),
    .border           (border),
    .dotclock_divider (dotclock_divider),
    .de_stretched     (de_stretched),
    .hs_rise          (hs_rise),
    .vs_rise          (vs_rise),
    .raw_de           (raw_de),
    .border_active    (border_active),
    .pixel_count      (pixel_count),
    .line_count       (line_count),
    .line_started     (line_started),
    .frame_started    (frame_started),
    .video_slot       (video_slot),
    .de_stretched_prev(de_stretched_prev)
  );

  video_output_shaper u_shaper (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .overscan_enable  (overscan_enable),
    .dotclock_divider (dotclock_divider),
    .rgb_core         (rgb_core),
    .h_blank          (h_blank),
    .v_blank          (v_blank),
    .hs_rise          (hs_rise),
    .vs_rise          (vs_rise),
    .raw_de           (raw_de),
    .border_active    (border_active),
    .pixel_count      (pixel_count),
    .line_count       (line_count),
    .line_started     (line_started),
    .frame_started    (frame_started),
    .video_slot       (video_slot),
    .de_stretched_prev(de_stretched_prev),
    .video_de         (video_de),
    .video_rgb        (video_rgb),
    .video_vs         (video_vs),
    .video_hs         (video_hs),
    .de_stretched     (de_stretched)
  );

endmodule

/* verilog/video_line_tracker.sv */
//////////////////////////////
// follows the raw console video: sync edges, border masking,
// pixel and line counters and the mode of the widest line
//////////////////////////////

`timescale 1ns/1ps

module video_line_tracker
  import core_pkg::*;
(
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,

  input  logic                         h_blank,
  input  logic                         v_blank,
  input  logic                         hsync_core,
  input  logic                         vsync_core,
  input  logic                         border,
  input  dot_mode_t                    dotclock_divider,
  input  logic                         de_stretched,

  output logic                         hs_rise,
  output logic                         vs_rise,
  output logic                         raw_de,
  output logic                         border_active,
  output logic [pixel_count_width-1:0] pixel_count,
  output logic [line_count_width-1:0]  line_count,
  output logic                         line_started,
  output logic                         frame_started,
  output video_slot_t                  video_slot,
  output logic                         de_stretched_prev
);

  logic                          hs_prev;
  logic                          vs_prev;
  logic                          raw_de_prev;
  dot_mode_t                     dot_prev;
  logic [border_count_width-1:0] border_count;
  logic [pixel_count_width-1:0]  max_pixel_count;
  logic                          raw_de_fall;

  assign hs_rise       = hsync_core && !hs_prev;
  assign vs_rise       = vsync_core && !vs_prev;
  assign border_active = border || (border_count != '0);
  assign raw_de        = !h_blank && !v_blank && !border_active;
  assign raw_de_fall   = raw_de_prev && !raw_de;

  //////////////////////////////
  // history registers
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev           <= 1'b0;
      vs_prev           <= 1'b0;
      raw_de_prev       <= 1'b0;
      de_stretched_prev <= 1'b0;
      dot_prev          <= dot_256;
    end else begin
      hs_prev           <= hsync_core;
      vs_prev           <= vsync_core;
      raw_de_prev       <= raw_de;
      de_stretched_prev <= de_stretched;
      dot_prev          <= dotclock_divider;
    end
  end

  // reloads while border is high, then runs out
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      border_count <= '0;
    end else if (border) begin
      border_count <= border_count_width'(border_hold);
    end else if (border_count != '0) begin
      border_count <= border_count - 1'b1;
    end
  end

  //////////////////////////////
  // pixel and line counters
  //////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pixel_count   <= '0;
      line_started  <= 1'b0;
      line_count    <= '0;
      frame_started <= 1'b0;
    end else begin
      // keep counting to hsync once the first active pixel shows up
      if (hs_rise) begin
        pixel_count  <= '0;
        line_started <= 1'b0;
      end else if (raw_de || line_started) begin
        pixel_count  <= pixel_count + 1'b1;
        line_started <= 1'b1;
      end

      if (vs_rise) begin
        line_count    <= '0;
        frame_started <= 1'b0;
      end else begin
        if (hs_rise && frame_started) begin
          line_count <= line_count + 1'b1;
        end
        if (!hs_rise && (raw_de || line_started)) begin
          frame_started <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // mode detection
  //////////////////////////////

  // widest line so far; a dot mode switch makes the old tally stale
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      max_pixel_count <= '0;
    end else if (hs_rise || (dotclock_divider != dot_prev)) begin
      max_pixel_count <= '0;
    end else if (raw_de_fall && (pixel_count > max_pixel_count)) begin
      max_pixel_count <= pixel_count;
    end
  end

  // 512 wide lines share code 0 with 256
  always_comb begin
    if (max_pixel_count > slot_thresh_512) begin
      video_slot = slot_256;
    end else if (max_pixel_count > slot_thresh_352) begin
      video_slot = slot_352;
    end else if (max_pixel_count > slot_thresh_320) begin
      video_slot = slot_320;
    end else begin
      video_slot = slot_256;
    end
  end

endmodule

/* verilog/video_output_shaper.sv */
//////////////////////////////
// shapes tracked console video for the scaler: stretched data
// enable, border masking, sync pulses and the end-of-line mode word
//////////////////////////////

`timescale 1ns/1ps

module video_output_shaper
  import core_pkg::*;
(
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,

  input  logic                         overscan_enable,
  input  dot_mode_t                    dotclock_divider,
  input  logic [rgb_width-1:0]         rgb_core,
  input  logic                         h_blank,
  input  logic                         v_blank,

  input  logic                         hs_rise,
  input  logic                         vs_rise,
  input  logic                         raw_de,
  input  logic                         border_active,
  input  logic [pixel_count_width-1:0] pixel_count,
  input  logic [line_count_width-1:0]  line_count,
  input  logic                         line_started,
  input  logic                         frame_started,
  input  video_slot_t                  video_slot,
  input  logic                         de_stretched_prev,

  output logic                         video_de,
  output logic [rgb_width-1:0]         video_rgb,
  output logic                         video_vs,
  output logic                         video_hs,
  output logic                         de_stretched
);

  logic [pixel_count_width-1:0] line_width;
  logic [line_count_width-1:0]  frame_lines;
  logic                         h_blank_ext;
  logic                         v_blank_ext;
  logic                         border_ext;
  logic                         line_end;
  logic [rgb_width-1:0]         mode_word;
  logic [hs_count_width-1:0]    hs_count;

  // 256 mode is pixel doubled, so only 352 differs
  assign line_width  = (dotclock_divider == dot_352) ? line_width_narrow : line_width_wide;
  assign frame_lines = overscan_enable ? lines_overscan : lines_full;

  //////////////////////////////
  // stretched data enable
  //////////////////////////////

  // blanking only counts once the line or frame is long enough
  assign h_blank_ext = h_blank && !(line_started && (pixel_count < line_width));
  assign v_blank_ext = v_blank && !(frame_started && (line_count < lines_full));
  assign border_ext  = border_active && (pixel_count < border_pixels);

  assign de_stretched = !h_blank_ext && !v_blank_ext && !border_ext &&
                        (pixel_count < line_width) && (line_count < frame_lines);
  assign video_de     = de_stretched;

  //////////////////////////////
  // rgb and end-of-line word
  //////////////////////////////

  assign line_end = de_stretched_prev && !de_stretched;

  // scaler reads the mode from bits 15:13 after the last pixel
  always_comb begin
    mode_word        = '0;
    mode_word[15:14] = video_slot;
    mode_word[13]    = overscan_enable;
  end

  always_comb begin
    if (raw_de) begin
      video_rgb = rgb_core;
    end else if (line_end) begin
      video_rgb = mode_word;
    end else begin
      video_rgb = '0;
    end
  end

  //////////////////////////////
  // sync pulses
  //////////////////////////////

  // single cycle on the raw vsync rise
  assign video_vs = vs_rise;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_count <= '0;
    end else if (hs_rise) begin
      hs_count <= hs_count_width'(hs_hold);
    end else if (hs_count != '0) begin
      hs_count <= hs_count - 1'b1;
    end
  end

  // lands hs_hold cycles after the raw rise
  assign video_hs = (hs_count == hs_count_width'(1));

endmodule
